// ==== Makefile ====
# Verilator lint and simulation of the video register front end.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_xm_regs
RTL_TOP   ?= xm_regs_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/xm_bus_decode.sv ====
// Host bus front end. Brings the async chip select into the clock domain
// and turns each select low period into one read or write strobe.
// Bus fields are sampled raw on the strobe edge; the host keeps them
// stable while select is low.

`timescale 1ns/10ps
`include "xm_params.svh"

module xm_bus_decode (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            bus_cs_n_i,         // async select, active low
    input  logic            bus_rd_nwr_i,       // 1 = read, 0 = write
    input  logic            bus_bytesel_i,      // 0 = even byte
    input  logic [3:0]      bus_reg_num_i,
    input  xm_pkg::byte_t   bus_data_i,
    xm_cmd_if.decode        cmd
);
    import xm_pkg::*;

    localparam int SYNC_N = `XM_SYNC_STAGES;

    logic [SYNC_N-1:0]  cs_sync;        // select sync chain, bit 0 first
    logic               cs_last;        // previous synced select
    logic               cs_fall;        // select just went active

    assign cs_fall = cs_last & ~cs_sync[SYNC_N-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync           <= '1;        // idle = deselected
            cs_last           <= 1'b1;
            cmd.write_strobe  <= 1'b0;
            cmd.read_strobe   <= 1'b0;
            cmd.reg_num       <= SYS_CTRL;
            cmd.bytesel       <= 1'b0;
            cmd.data_byte     <= '0;
        end else begin
            cs_sync           <= {cs_sync[SYNC_N-2:0], bus_cs_n_i};
            cs_last           <= cs_sync[SYNC_N-1];
            cmd.write_strobe  <= 1'b0;      // single cycle pulses
            cmd.read_strobe   <= 1'b0;

            if (cs_fall) begin
                cmd.write_strobe  <= ~bus_rd_nwr_i;
                cmd.read_strobe   <= bus_rd_nwr_i;
                cmd.reg_num       <= xm_reg_e'(bus_reg_num_i);
                cmd.bytesel       <= bus_bytesel_i;
                cmd.data_byte     <= bus_data_i;    // ignored on reads
            end
        end
    end

endmodule

// ==== design/xm_cmd_if.sv ====
// One decoded host byte cycle, from the bus decoder to execute and readback.
// Strobes are single cycle; fields hold until the next strobe.

`timescale 1ns/10ps

interface xm_cmd_if;
    import xm_pkg::*;

    logic       write_strobe;   // host byte write
    logic       read_strobe;    // host byte read
    xm_reg_e    reg_num;        // register addressed
    logic       bytesel;        // 0 = even/high byte, 1 = odd/low
    byte_t      data_byte;      // byte written by host

    modport decode (
        output write_strobe, read_strobe, reg_num, bytesel, data_byte
    );

    modport sink (
        input  write_strobe, read_strobe, reg_num, bytesel, data_byte
    );

endinterface

// ==== design/xm_params.svh ====
// Width, synchronizer and timer constants shared by the register front end.
// Included by the package and by any module that needs a raw constant.
// The timer fraction is the reduced ratio of clock rate to tick rate.

`ifndef XM_PARAMS_SVH
`define XM_PARAMS_SVH

// bus word and address width
`define XM_WORD_W              16

// flops on the async chip select before edge detect
`define XM_SYNC_STAGES         2

// 10 kHz tick from a 25.125 MHz pixel clock, reduced fraction 2/5025
`define XM_TIMER_CLK_REDUCED   5025
`define XM_TIMER_HZ_REDUCED    2

`endif

// ==== design/xm_pkg.sv ====
// Shared types of the video register front end.
// Import with a wildcard inside a module body. Use scoped names in port lists.

`include "xm_params.svh"

package xm_pkg;

    typedef logic [7:0]              byte_t;     // one host bus byte
    typedef logic [`XM_WORD_W-1:0]   word_t;     // register / memory word
    typedef logic [`XM_WORD_W-1:0]   addr_t;     // vram or xr address
    typedef logic [3:0]              wrmask_t;   // vram nibble write enables

    // host visible register numbers
    typedef enum logic [3:0] {
        SYS_CTRL   = 4'h0,
        INT_CTRL   = 4'h1,      // reads zero here
        TIMER      = 4'h2,
        RD_XADDR   = 4'h3,
        WR_XADDR   = 4'h4,
        XDATA      = 4'h5,
        RD_INCR    = 4'h6,
        RD_ADDR    = 4'h7,
        WR_INCR    = 4'h8,
        WR_ADDR    = 4'h9,
        DATA       = 4'hA,
        DATA_2     = 4'hB,      // alias of DATA
        UNUSED_0C  = 4'hC,
        UNUSED_0D  = 4'hD,
        UNUSED_0E  = 4'hE,
        UNUSED_0F  = 4'hF
    } xm_reg_e;

    // kind of memory access in flight
    typedef enum logic [2:0] {
        OP_IDLE     = 3'd0,
        OP_VRAM_RD  = 3'd1,
        OP_VRAM_WR  = 3'd2,
        OP_XR_RD    = 3'd3,
        OP_XR_WR    = 3'd4
    } mem_op_e;

endpackage

// ==== design/xm_readback.sv ====
// Read side of the register front end: free running tenth of a
// millisecond timer plus the byte mux that drives host read data.
// Even byte reads latch the timer low byte so a high/low pair is coherent.

`timescale 1ns/10ps
`include "xm_params.svh"

module xm_readback #(
    parameter int CLK_REDUCED = `XM_TIMER_CLK_REDUCED,  // clock part of fraction
    parameter int HZ_REDUCED  = `XM_TIMER_HZ_REDUCED    // tick part of fraction
) (
    input  logic            clk,
    input  logic            reset_i,
    xm_cmd_if.sink          cmd,
    xm_view_if.sink         view,
    output xm_pkg::byte_t   bus_data_o
);
    import xm_pkg::*;

    localparam int FRAC_BITS = $clog2(CLK_REDUCED) + 1;    // one sign bit extra
    localparam logic [FRAC_BITS-1:0] FRAC_TICK = FRAC_BITS'(HZ_REDUCED - CLK_REDUCED);
    localparam logic [FRAC_BITS-1:0] FRAC_STEP = FRAC_BITS'(HZ_REDUCED);

    logic [FRAC_BITS-1:0]   frac;       // fractional accumulator
    logic                   tick;       // accumulator non-negative
    word_t                  timer;      // 1/10 ms count
    byte_t                  timer_lo;   // latched low byte
    word_t                  rd_word;    // selected register

    assign tick = ~frac[FRAC_BITS-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac     <= '0;
            timer    <= '0;
            timer_lo <= '0;
        end else begin
            if (tick) begin
                frac  <= frac + FRAC_TICK;      // goes negative again
                timer <= timer + 1'b1;
            end else begin
                frac  <= frac + FRAC_STEP;
            end
            if (cmd.read_strobe && !cmd.bytesel) timer_lo <= timer[7:0];
        end
    end

    always_comb begin
        case (cmd.reg_num)
            SYS_CTRL:  rd_word = {view.mem_wait, 11'b0, view.wrmask};
            INT_CTRL:  rd_word = '0;
            TIMER:     rd_word = {timer[15:8], timer_lo};   // live high, latched low
            RD_XADDR:  rd_word = view.rd_xaddr;
            WR_XADDR:  rd_word = view.wr_xaddr;
            XDATA:     rd_word = view.xdata;
            RD_INCR:   rd_word = view.rd_incr;
            RD_ADDR:   rd_word = view.rd_addr;
            WR_INCR:   rd_word = view.wr_incr;
            WR_ADDR:   rd_word = view.wr_addr;
            DATA, DATA_2, UNUSED_0C, UNUSED_0D, UNUSED_0E, UNUSED_0F:
                       rd_word = view.data;
            default:   rd_word = view.data;
        endcase
    end

    assign bus_data_o = cmd.bytesel ? rd_word[7:0] : rd_word[15:8];  // even = high

endmodule

// ==== design/xm_reg_execute.sv ====
// Register file and memory access control. Host byte writes fill the
// address, increment and data registers; the odd byte of a data or read
// address register launches a VRAM or XR access. Reads pre-fetch, and
// addresses step after every completed access.
// Only one access at a time: a new start simply replaces the current one.

`timescale 1ns/10ps

module xm_reg_execute (
    input  logic            clk,
    input  logic            reset_i,
    xm_cmd_if.sink          cmd,
    xm_view_if.source       view,
    input  logic            vram_ack_i,         // one cycle, data valid
    input  logic            xr_ack_i,
    input  xm_pkg::word_t   vram_data_i,
    input  xm_pkg::word_t   xr_data_i,
    output logic            vram_sel_o,
    output logic            xr_sel_o,
    output logic            mem_wr_o,
    output xm_pkg::wrmask_t wrmask_o,
    output xm_pkg::addr_t   addr_o,
    output xm_pkg::word_t   data_o
);
    import xm_pkg::*;

    addr_t      rd_xaddr, wr_xaddr;     // xr pointers
    addr_t      rd_addr, wr_addr;       // vram pointers
    word_t      rd_incr, wr_incr;       // vram steps
    word_t      xdata, data;            // pre-read words
    byte_t      xdata_even, data_even;  // held even bytes of pending writes
    mem_op_e    op;                     // access in flight

    mem_op_e    start_op;               // access to launch this cycle
    addr_t      start_addr;
    word_t      start_data;

    // replace one byte of a word, odd byte is the low one
    function automatic word_t put_byte(word_t w, logic odd, byte_t b);
        word_t r;
        r = w;
        if (odd) r[7:0] = b;
        else     r[15:8] = b;
        return r;
    endfunction

    // which access the current strobe launches, if any
    always_comb begin
        start_op   = OP_IDLE;
        start_addr = addr_o;
        start_data = data_o;
        if (cmd.write_strobe && cmd.bytesel) begin
            case (cmd.reg_num)
                RD_XADDR: begin
                    start_op   = OP_XR_RD;
                    start_addr = {rd_xaddr[15:8], cmd.data_byte};   // new addr
                end
                XDATA: begin
                    start_op   = OP_XR_WR;
                    start_addr = wr_xaddr;
                    start_data = {xdata_even, cmd.data_byte};
                end
                RD_ADDR: begin
                    start_op   = OP_VRAM_RD;
                    start_addr = {rd_addr[15:8], cmd.data_byte};
                end
                DATA, DATA_2: begin
                    start_op   = OP_VRAM_WR;
                    start_addr = wr_addr;
                    start_data = {data_even, cmd.data_byte};
                end
                default: ;
            endcase
        end else if (cmd.read_strobe && cmd.bytesel) begin
            if (cmd.reg_num == XDATA) begin             // next xr word
                start_op   = OP_XR_RD;
                start_addr = rd_xaddr;
            end else if (cmd.reg_num == DATA || cmd.reg_num == DATA_2) begin
                start_op   = OP_VRAM_RD;                // next vram word
                start_addr = rd_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_xaddr   <= '0;
            wr_xaddr   <= '0;
            rd_addr    <= '0;
            wr_addr    <= '0;
            rd_incr    <= '0;
            wr_incr    <= '0;
            xdata      <= '0;
            data       <= '0;
            xdata_even <= '0;
            data_even  <= '0;
            op         <= OP_IDLE;
            vram_sel_o <= 1'b0;
            xr_sel_o   <= 1'b0;
            mem_wr_o   <= 1'b0;
            wrmask_o   <= '1;           // all nibbles enabled
            addr_o     <= '0;
            data_o     <= '0;
        end else begin
            if (vram_ack_i && vram_sel_o) begin
                if (op == OP_VRAM_RD) begin
                    data    <= vram_data_i;
                    rd_addr <= rd_addr + rd_incr;
                end
                if (op == OP_VRAM_WR) wr_addr <= wr_addr + wr_incr;
                vram_sel_o <= 1'b0;
                mem_wr_o   <= 1'b0;
                op         <= OP_IDLE;
            end
            if (xr_ack_i && xr_sel_o) begin
                if (op == OP_XR_RD) begin
                    xdata    <= xr_data_i;
                    rd_xaddr <= rd_xaddr + 1'b1;    // xr always steps by one
                end
                if (op == OP_XR_WR) wr_xaddr <= wr_xaddr + 1'b1;
                xr_sel_o <= 1'b0;
                mem_wr_o <= 1'b0;
                op       <= OP_IDLE;
            end

            if (cmd.write_strobe) begin
                case (cmd.reg_num)
                    SYS_CTRL: if (cmd.bytesel) wrmask_o <= cmd.data_byte[3:0];
                    RD_XADDR: rd_xaddr <= put_byte(rd_xaddr, cmd.bytesel, cmd.data_byte);
                    WR_XADDR: wr_xaddr <= put_byte(wr_xaddr, cmd.bytesel, cmd.data_byte);
                    RD_INCR:  rd_incr  <= put_byte(rd_incr, cmd.bytesel, cmd.data_byte);
                    RD_ADDR:  rd_addr  <= put_byte(rd_addr, cmd.bytesel, cmd.data_byte);
                    WR_INCR:  wr_incr  <= put_byte(wr_incr, cmd.bytesel, cmd.data_byte);
                    WR_ADDR:  wr_addr  <= put_byte(wr_addr, cmd.bytesel, cmd.data_byte);
                    XDATA:    if (!cmd.bytesel) xdata_even <= cmd.data_byte;
                    DATA, DATA_2: if (!cmd.bytesel) data_even <= cmd.data_byte;
                    default: ;                          // int ctrl, timer, unused
                endcase
            end

            if (start_op != OP_IDLE) begin              // overrides any ack above
                op         <= start_op;
                vram_sel_o <= (start_op == OP_VRAM_RD) || (start_op == OP_VRAM_WR);
                xr_sel_o   <= (start_op == OP_XR_RD) || (start_op == OP_XR_WR);
                mem_wr_o   <= (start_op == OP_VRAM_WR) || (start_op == OP_XR_WR);
                addr_o     <= start_addr;
                data_o     <= start_data;
            end
        end
    end

    assign view.rd_xaddr = rd_xaddr;
    assign view.wr_xaddr = wr_xaddr;
    assign view.rd_addr  = rd_addr;
    assign view.wr_addr  = wr_addr;
    assign view.rd_incr  = rd_incr;
    assign view.wr_incr  = wr_incr;
    assign view.xdata    = xdata;
    assign view.data     = data;
    assign view.wrmask   = wrmask_o;
    assign view.mem_wait = (op != OP_IDLE);

endmodule

// ==== design/xm_regs_top.sv ====
// Top of the video register front end. Host bus on one side, a single
// VRAM/XR access port on the other. Connects the bus decoder, the register
// execute block and the readback mux through two internal interfaces.

`timescale 1ns/10ps

module xm_regs_top (
    input  logic            clk,
    input  logic            reset_i,
    // host bus
    input  logic            bus_cs_n_i,
    input  logic            bus_rd_nwr_i,
    input  logic            bus_bytesel_i,
    input  logic [3:0]      bus_reg_num_i,
    input  xm_pkg::byte_t   bus_data_i,
    output xm_pkg::byte_t   bus_data_o,
    // vram / xr access
    input  logic            vram_ack_i,
    input  logic            xr_ack_i,
    input  xm_pkg::word_t   vram_data_i,
    input  xm_pkg::word_t   xr_data_i,
    output logic            vram_sel_o,
    output logic            xr_sel_o,
    output logic            mem_wr_o,
    output xm_pkg::wrmask_t wrmask_o,
    output xm_pkg::addr_t   addr_o,
    output xm_pkg::word_t   data_o
);

    xm_cmd_if   cmd_if ();      // decoded byte cycles
    xm_view_if  view_if ();     // register contents for readback

    xm_bus_decode xm_bus_decode_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_data_i     (bus_data_i),
        .cmd            (cmd_if.decode)
    );

    xm_reg_execute xm_reg_execute_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .cmd            (cmd_if.sink),
        .view           (view_if.source),
        .vram_ack_i     (vram_ack_i),
        .xr_ack_i       (xr_ack_i),
        .vram_data_i    (vram_data_i),
        .xr_data_i      (xr_data_i),
        .vram_sel_o     (vram_sel_o),
        .xr_sel_o       (xr_sel_o),
        .mem_wr_o       (mem_wr_o),
        .wrmask_o       (wrmask_o),
        .addr_o         (addr_o),
        .data_o         (data_o)
    );

    xm_readback xm_readback_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .cmd            (cmd_if.sink),
        .view           (view_if.sink),
        .bus_data_o     (bus_data_o)
    );

endmodule

// ==== design/xm_view_if.sv ====
// Register contents of the execute block as seen by the readback mux.
// Execute drives the source side, readback only looks.

`timescale 1ns/10ps

interface xm_view_if;
    import xm_pkg::*;

    addr_t      rd_xaddr;       // xr read address
    addr_t      wr_xaddr;       // xr write address
    addr_t      rd_addr;        // vram read address
    addr_t      wr_addr;        // vram write address
    word_t      rd_incr;        // vram read step
    word_t      wr_incr;        // vram write step
    word_t      xdata;          // last xr word read
    word_t      data;           // last vram word read
    wrmask_t    wrmask;         // vram nibble mask
    logic       mem_wait;       // access still in flight

    modport source (
        output rd_xaddr, wr_xaddr, rd_addr, wr_addr, rd_incr, wr_incr,
        output xdata, data, wrmask, mem_wait
    );

    modport sink (
        input  rd_xaddr, wr_xaddr, rd_addr, wr_addr, rd_incr, wr_incr,
        input  xdata, data, wrmask, mem_wait
    );

endinterface

// ==== sim/tb_xm_regs.sv ====
// Testbench for the video register front end. Plays the bus operations of
// sim/xm_stim.txt against the DUT, with VRAM and XR models on the access port.
// Run from the project root so the stim path resolves.

`timescale 1ns/10ps
`include "xm_params.svh"

module tb_xm_regs;
    import xm_pkg::*;

    localparam int STIM_DEPTH = 256;
    localparam int IDLE_LIMIT = 64;     // idle wait limit in cycles, model ack within 6
    localparam int TIMER_GAP  = (`XM_TIMER_CLK_REDUCED / `XM_TIMER_HZ_REDUCED) * 3 + 100;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    logic       bus_bytesel;
    logic [3:0] bus_reg_num;
    byte_t      bus_data_in;
    byte_t      bus_data_out;
    logic       vram_ack;
    logic       xr_ack;
    word_t      vram_rdata;
    word_t      xr_rdata;
    logic       vram_sel;
    logic       xr_sel;
    logic       mem_wr;
    wrmask_t    wrmask;
    addr_t      addr;
    word_t      wdata;

    word_t       vram_mem [0:65535];
    word_t       xr_mem [0:65535];
    addr_t       vram_wr_addr;          // last write seen by each model
    addr_t       xr_wr_addr;
    logic [15:0] stim [0:STIM_DEPTH-1]; // 4 entries per stim line
    int          value_errors = 0;
    int          other_errors = 0;
    logic        aborted = 1'b0;

    always #50 clk = ~clk;              // 100 ns period

    xm_regs_top xm_regs_top_i (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_bytesel_i(bus_bytesel),
        .bus_reg_num_i(bus_reg_num), .bus_data_i(bus_data_in), .bus_data_o(bus_data_out),
        .vram_ack_i(vram_ack), .xr_ack_i(xr_ack),
        .vram_data_i(vram_rdata), .xr_data_i(xr_rdata),
        .vram_sel_o(vram_sel), .xr_sel_o(xr_sel), .mem_wr_o(mem_wr),
        .wrmask_o(wrmask), .addr_o(addr), .data_o(wdata)
    );

    // nibble n of the word is written only when mask bit n is set
    function automatic word_t apply_mask(word_t old_w, word_t new_w, wrmask_t m);
        word_t r;
        for (int n = 0; n < 4; n++) begin
            r[n*4 +: 4] = m[n] ? new_w[n*4 +: 4] : old_w[n*4 +: 4];
        end
        return r;
    endfunction

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // one host byte cycle: select low 5 cycles, high 2
    task automatic bus_op(input logic rd, input logic [3:0] reg_n, input logic sel,
                          input byte_t wr_byte, output byte_t rd_byte);
        @(posedge clk);
        bus_cs_n    <= 1'b0;
        bus_rd_nwr  <= rd;
        bus_bytesel <= sel;
        bus_reg_num <= reg_n;
        bus_data_in <= wr_byte;
        repeat (3) @(posedge clk);      // strobe lands on the third low edge
        @(negedge clk);
        rd_byte = bus_data_out;         // mux settled before any fetch lands
        repeat (2) @(posedge clk);
        bus_cs_n <= 1'b1;
        @(posedge clk);
    endtask

    // every address and increment register reads zero out of reset
    task automatic check_reset_values();
        xm_reg_e regs [6];
        byte_t   got;
        regs = '{RD_XADDR, WR_XADDR, RD_INCR, RD_ADDR, WR_INCR, WR_ADDR};
        foreach (regs[i]) begin
            for (int b = 0; b < 2; b++) begin
                bus_op(1'b1, regs[i], b[0], 8'h00, got);
                check_byte($sformatf("bus_data_o %s byte %0d", regs[i].name(), b),
                           got, 8'h00);
            end
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((vram_sel || xr_sel) && cycles < IDLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (vram_sel || xr_sel) begin
            $display("%0t timeout: memory access still pending after %0d cycles",
                     $time, IDLE_LIMIT);
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    // high byte latches the low byte, so each pair is one coherent count
    task automatic check_timer();
        byte_t hi;
        byte_t lo;
        word_t first;
        word_t second;
        bus_op(1'b1, TIMER, 1'b0, 8'h00, hi);
        bus_op(1'b1, TIMER, 1'b1, 8'h00, lo);
        first = {hi, lo};
        repeat (TIMER_GAP) @(posedge clk);   // at least three ticks
        bus_op(1'b1, TIMER, 1'b0, 8'h00, hi);
        bus_op(1'b1, TIMER, 1'b1, 8'h00, lo);
        second = {hi, lo};
        if (second <= first) begin
            $display("%0t timer did not advance: first %h second %h", $time, first, second);
            other_errors++;
        end
    endtask

    task automatic run_line(input logic [3:0] op, input logic [3:0] reg_n,
                            input logic sel, input logic [15:0] val);
        byte_t   got;
        xm_reg_e r;
        r = xm_reg_e'(reg_n);
        case (op)
            4'h1: bus_op(1'b0, reg_n, sel, val[7:0], got);
            4'h2: begin
                bus_op(1'b1, reg_n, sel, 8'h00, got);
                check_byte($sformatf("bus_data_o %s byte %0d", r.name(), sel), got, val[7:0]);
            end
            4'h3: wait_idle();
            4'h4: check_addr("vram write addr_o", vram_wr_addr, val);
            4'h5: check_word("vram stored word", vram_mem[vram_wr_addr], val);
            4'h6: check_addr("xr write addr_o", xr_wr_addr, val);
            4'h7: check_word("xr stored word", xr_mem[xr_wr_addr], val);
            4'h8: check_timer();
            default: begin
                $display("unknown stim operation %h", op);
                other_errors++;
            end
        endcase
    endtask

    task automatic finish_run();
        int unsigned assert_errors;
        assert_errors = xm_regs_top_i.xm_regs_asserts_i.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin : vram_model
        int unsigned dly;
        vram_ack     <= 1'b0;
        vram_rdata   <= '0;
        vram_wr_addr = '0;
        forever begin
            @(posedge clk);
            if (vram_sel) begin
                dly = 1 + ($urandom % 6);
                repeat (dly - 1) @(posedge clk);
                vram_ack   <= 1'b1;
                vram_rdata <= vram_mem[addr];
                if (mem_wr) begin
                    vram_mem[addr] = apply_mask(vram_mem[addr], wdata, wrmask);
                    vram_wr_addr   = addr;
                end
                @(posedge clk);
                vram_ack <= 1'b0;       // single cycle ack
            end
        end
    end

    initial begin : xr_model
        int unsigned dly;
        xr_ack     <= 1'b0;
        xr_rdata   <= '0;
        xr_wr_addr = '0;
        forever begin
            @(posedge clk);
            if (xr_sel) begin
                dly = 1 + ($urandom % 6);
                repeat (dly - 1) @(posedge clk);
                xr_ack   <= 1'b1;
                xr_rdata <= xr_mem[addr];
                if (mem_wr) begin
                    xr_mem[addr] = wdata;   // xr bus has no mask
                    xr_wr_addr   = addr;
                end
                @(posedge clk);
                xr_ack <= 1'b0;
            end
        end
    end

    initial begin : main
        int idx;
        void'($urandom(7320));          // seeds the model delays
        reset_i     <= 1'b1;
        bus_cs_n    <= 1'b1;
        bus_rd_nwr  <= 1'b1;
        bus_bytesel <= 1'b0;
        bus_reg_num <= 4'h0;
        bus_data_in <= 8'h00;
        for (int a = 0; a < 65536; a++) begin
            vram_mem[a] = {a[7:0], a[15:8]};    // byte swapped address
            xr_mem[a]   = ~a[15:0];
        end
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim[i] = '0;
        end
        $readmemh("sim/xm_stim.txt", stim);
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        check_reset_values();
        idx = 0;
        while (!aborted && idx + 3 < STIM_DEPTH && stim[idx][3:0] != 4'h0) begin
            run_line(stim[idx][3:0], stim[idx+1][3:0], stim[idx+2][0], stim[idx+3]);
            idx = idx + 4;
        end
        finish_run();
    end

endmodule

// ==== sim/xm_regs_asserts.sv ====
// Concurrent checks on the access port and the decoded bus strobes.
// Attached to the register front end top by the bind below.

`timescale 1ns/10ps

module xm_regs_asserts (
    input logic clk,
    input logic reset_i,
    input logic vram_sel_o,
    input logic xr_sel_o,
    input logic mem_wr_o,
    input logic write_strobe,
    input logic read_strobe
);

    int unsigned fail_count = 0;    // assertion failures so far

    one_select: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_sel_o && xr_sel_o))
        else begin
            fail_count++;
            $error("vram and xr selected together");
        end

    wr_needs_select: assert property (@(posedge clk) disable iff (reset_i)
        mem_wr_o |-> (vram_sel_o || xr_sel_o))
        else begin
            fail_count++;
            $error("mem_wr_o high with no select");
        end

    // sync reset, so selects are low from the edge after reset is seen
    reset_deselects: assert property (@(posedge clk)
        reset_i |=> !(vram_sel_o || xr_sel_o))
        else begin
            fail_count++;
            $error("select high during reset");
        end

    wr_strobe_single: assert property (@(posedge clk) disable iff (reset_i)
        write_strobe |=> !write_strobe)
        else begin
            fail_count++;
            $error("write strobe longer than one cycle");
        end

    rd_strobe_single: assert property (@(posedge clk) disable iff (reset_i)
        read_strobe |=> !read_strobe)
        else begin
            fail_count++;
            $error("read strobe longer than one cycle");
        end

endmodule

bind xm_regs_top xm_regs_asserts xm_regs_asserts_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .vram_sel_o   (vram_sel_o),
    .xr_sel_o     (xr_sel_o),
    .mem_wr_o     (mem_wr_o),
    .write_strobe (cmd_if.write_strobe),
    .read_strobe  (cmd_if.read_strobe)
);

// ==== sim/xm_stim.txt ====
// columns: op reg bytesel value, all hex; bytesel 0 = high byte
// op 1 write, 2 read and compare, 3 wait idle, 4/5 vram write addr/word,
// op 6/7 xr write addr/word, 8 timer pair, 0 or end of file stops
2 0 1 0F
2 7 1 00
2 4 0 00
1 6 1 01
1 8 0 01
1 8 1 02
1 9 0 12
1 9 1 34
2 8 0 01
2 8 1 02
2 9 0 12
2 9 1 34
2 6 1 01
1 0 1 0C
1 A 0 AB
1 A 1 CD
3 0 0 0
4 0 0 1234
5 0 0 AB12
2 9 0 13
2 9 1 36
1 7 0 20
1 7 1 40
3 0 0 0
2 7 1 41
2 A 0 40
2 A 1 20
3 0 0 0
2 A 0 41
1 4 1 10
1 5 0 55
1 5 1 AA
3 0 0 0
6 0 0 0010
7 0 0 55AA
2 4 1 11
1 3 1 10
3 0 0 0
2 5 0 55
2 5 1 AA
3 0 0 0
2 3 1 12
2 5 0 FF
2 0 0 00
1 1 1 FF
1 2 1 FF
2 1 1 00
2 0 1 0C
8 0 0 0
0 0 0 0

// ==== tb.f ====
+incdir+design
design/xm_pkg.sv
design/xm_cmd_if.sv
design/xm_view_if.sv
design/xm_bus_decode.sv
design/xm_reg_execute.sv
design/xm_readback.sv
design/xm_regs_top.sv
sim/xm_regs_asserts.sv
sim/tb_xm_regs.sv
